// ==== Makefile ====
TOP = tb_object_tracker

.PHONY: compile run clean

compile:
	verilator --binary --timing -Wno-fatal -f filelist.f --top-module $(TOP)

# Pass only when the testbench prints its pass line
run: compile
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "^Test OK$$"

clean:
	rm -rf obj_dir

// ==== common/vision_pkg.sv ====
package vision_pkg;

    // ------------------------------------------------------------
    // Pixel and coordinate types
    // ------------------------------------------------------------

    // Column or row index
    typedef logic [9:0] coord_t;

    // One RGB444 camera pixel
    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } rgb444_t;

    // Gray level, also the processed pixel
    typedef logic [3:0] gray_t;

    // ------------------------------------------------------------
    // Centroid types
    // ------------------------------------------------------------

    // Foreground pixel count per frame
    typedef logic [19:0] area_t;

    // Coordinate sum over all foreground pixels
    typedef logic [27:0] coord_sum_t;

    // Pan/tilt direction code
    typedef logic [3:0] motor_dir_t;

    // Bit positions inside motor_dir_t
    localparam int DIR_UP    = 0;
    localparam int DIR_DOWN  = 1;
    localparam int DIR_LEFT  = 2;
    localparam int DIR_RIGHT = 3;

endpackage

// ==== filelist.f ====
+incdir+verification
common/vision_pkg.sv
hw/cam_capture/cam_byte_assembler.sv
hw/cam_capture/cam_line_tracker.sv
hw/pixel_proc/gray_threshold.sv
hw/pixel_proc/centroid_accumulator.sv
hw/motor_direction.sv
hw/object_tracker_top.sv
verification/tb_object_tracker.sv

// ==== hw/cam_capture/cam_byte_assembler.sv ====
`timescale 1ns/1ps

module cam_byte_assembler #(
    parameter int FRAME_WIDTH = 640
) (
    input  logic                pclk,
    input  logic                r2_rst_pclk,
    input  logic [7:0]          pix_byte,
    input  logic                href,
    output vision_pkg::rgb444_t pix_data,
    output vision_pkg::coord_t  pix_x,
    output logic                pix_valid
);

    import vision_pkg::*;

    // ------------------------------------------------------------
    // Byte pairing state
    // ------------------------------------------------------------

    // Low on the first byte of a pair, high on the second
    logic       byte_phase;
    // Red nibble held from the first byte
    logic [3:0] red_hold;
    // Column of the next pixel in the line
    coord_t     col_cnt;

    // ------------------------------------------------------------
    // Phase, column and strobe
    // ------------------------------------------------------------
    always_ff @(posedge pclk or negedge r2_rst_pclk) begin
        if (!r2_rst_pclk) begin
            byte_phase <= 1'b0;
            col_cnt    <= '0;
            pix_x      <= '0;
            pix_valid  <= 1'b0;
        end else begin
            pix_valid <= 1'b0;
            if (!href) begin
                // Outside a line, restart pairing and column
                byte_phase <= 1'b0;
                col_cnt    <= '0;
                pix_x      <= '0;
            end else if (!byte_phase) begin
                byte_phase <= 1'b1;
            end else begin
                // Second byte completes a pixel
                byte_phase <= 1'b0;
                pix_valid  <= 1'b1;
                pix_x      <= col_cnt;
                // Hold at the last column on overlong lines
                if (col_cnt != coord_t'(FRAME_WIDTH - 1)) begin
                    col_cnt <= col_cnt + 1'b1;
                end
            end
        end
    end

    // ------------------------------------------------------------
    // Pixel data
    // ------------------------------------------------------------
    always_ff @(posedge pclk) begin
        // First byte: xxxx RRRR
        if (href && !byte_phase) begin
            red_hold <= pix_byte[3:0];
        end
        // Second byte: GGGG BBBB
        if (href && byte_phase) begin
            pix_data <= '{r: red_hold, g: pix_byte[7:4], b: pix_byte[3:0]};
        end
    end

endmodule

// ==== hw/cam_capture/cam_line_tracker.sv ====
`timescale 1ns/1ps

module cam_line_tracker #(
    parameter int FRAME_HEIGHT = 480
) (
    input  logic               pclk,
    input  logic               r2_rst_pclk,
    input  logic               href,
    input  logic               vsync,
    output vision_pkg::coord_t line_y,
    output logic               line_ready,
    output logic               frame_end
);

    import vision_pkg::*;

    // Delayed copies for edge detection
    logic href_d1;
    logic vsync_d1;
    logic vsync_d2;

    // Edge strobes
    logic href_fall;
    logic vsync_fall;
    logic vsync_rise;

    assign href_fall  = href_d1 && !href;
    // Vsync edges come from the two delayed copies
    assign vsync_fall = vsync_d2 && !vsync_d1;
    assign vsync_rise = vsync_d1 && !vsync_d2;

    // ------------------------------------------------------------
    // Row counter and line/frame pulses
    // ------------------------------------------------------------
    always_ff @(posedge pclk or negedge r2_rst_pclk) begin
        if (!r2_rst_pclk) begin
            href_d1    <= 1'b0;
            vsync_d1   <= 1'b0;
            vsync_d2   <= 1'b0;
            line_y     <= '0;
            line_ready <= 1'b0;
            frame_end  <= 1'b0;
        end else begin
            href_d1    <= href;
            vsync_d1   <= vsync;
            vsync_d2   <= vsync_d1;
            line_ready <= 1'b0;
            // End of frame when vsync goes active
            frame_end  <= vsync_rise;

            // New frame starts at row 0
            if (vsync_fall) begin
                line_y <= '0;
            end

            // Line finished, move to the next row
            if (href_fall) begin
                line_ready <= 1'b1;
                if (line_y == coord_t'(FRAME_HEIGHT - 1)) begin
                    line_y <= '0;
                end else begin
                    line_y <= line_y + 1'b1;
                end
            end
        end
    end

endmodule

// ==== hw/motor_direction.sv ====
`timescale 1ns/1ps

module motor_direction #(
    parameter int FRAME_WIDTH  = 640,
    parameter int FRAME_HEIGHT = 480,
    parameter int DEADBAND     = 16
) (
    input  logic                   pclk,
    input  logic                   r2_rst_pclk,
    input  logic                   motion_enable,
    input  vision_pkg::coord_t     centroid_x,
    input  vision_pkg::coord_t     centroid_y,
    input  logic                   centroid_valid,
    input  logic                   centroid_update,
    output vision_pkg::motor_dir_t direction
);

    import vision_pkg::*;

    // Frame centre
    localparam int CENTER_X = FRAME_WIDTH / 2;
    localparam int CENTER_Y = FRAME_HEIGHT / 2;

    motor_dir_t code_next;

    // ------------------------------------------------------------
    // Centre window compare
    // ------------------------------------------------------------
    always_comb begin
        code_next = '0;
        // Pan, target off to one side
        code_next[DIR_LEFT]  = int'(centroid_x) < CENTER_X - DEADBAND;
        code_next[DIR_RIGHT] = int'(centroid_x) > CENTER_X + DEADBAND;
        // Tilt, row 0 is the top
        code_next[DIR_UP]    = int'(centroid_y) < CENTER_Y - DEADBAND;
        code_next[DIR_DOWN]  = int'(centroid_y) > CENTER_Y + DEADBAND;
    end

    // ------------------------------------------------------------
    // Direction register
    // ------------------------------------------------------------
    always_ff @(posedge pclk or negedge r2_rst_pclk) begin
        if (!r2_rst_pclk) begin
            direction <= '0;
        end else if (!motion_enable) begin
            direction <= '0;
        end else if (centroid_update) begin
            // No target, no motion
            direction <= centroid_valid ? code_next : '0;
        end
    end

endmodule

// ==== hw/object_tracker_top.sv ====
`timescale 1ns/1ps

module object_tracker_top #(
    parameter int FRAME_WIDTH  = 640,
    parameter int FRAME_HEIGHT = 480,
    parameter int MIN_AREA     = 64,
    parameter int DEADBAND     = 16
) (
    input  logic                   pclk,
    input  logic                   r2_rst_pclk,
    // Camera bus
    input  logic [7:0]             pix_byte,
    input  logic                   vsync,
    input  logic                   href,
    // Processing controls
    input  logic                   threshold_enable,
    input  vision_pkg::gray_t      threshold_value,
    input  logic                   motion_enable,
    // Pixel stream
    output vision_pkg::gray_t      processed_pixel,
    output logic                   processed_valid,
    output vision_pkg::coord_t     cam_line_y,
    output logic                   cam_line_ready,
    // Tracking results
    output vision_pkg::coord_t     centroid_x,
    output vision_pkg::coord_t     centroid_y,
    output logic                   centroid_valid,
    output logic                   centroid_update,
    output vision_pkg::area_t      blob_area,
    output vision_pkg::motor_dir_t motor_direction
);

    import vision_pkg::*;

    // Assembled camera pixels
    rgb444_t pix_data;
    coord_t  pix_x;
    logic    pix_valid;

    // Frame boundary
    logic    frame_end;

    // Gray stage to accumulator
    logic    proc_fg;
    coord_t  proc_x;
    coord_t  proc_y;

    // ------------------------------------------------------------
    // Camera capture
    // ------------------------------------------------------------
    cam_byte_assembler #(
        .FRAME_WIDTH (FRAME_WIDTH)
    ) i_byte_asm (
        .pclk        (pclk),
        .r2_rst_pclk (r2_rst_pclk),
        .pix_byte    (pix_byte),
        .href        (href),
        .pix_data    (pix_data),
        .pix_x       (pix_x),
        .pix_valid   (pix_valid)
    );

    cam_line_tracker #(
        .FRAME_HEIGHT (FRAME_HEIGHT)
    ) i_line_trk (
        .pclk        (pclk),
        .r2_rst_pclk (r2_rst_pclk),
        .href        (href),
        .vsync       (vsync),
        .line_y      (cam_line_y),
        .line_ready  (cam_line_ready),
        .frame_end   (frame_end)
    );

    // ------------------------------------------------------------
    // Pixel processing
    // ------------------------------------------------------------
    gray_threshold i_gray (
        .pclk             (pclk),
        .r2_rst_pclk      (r2_rst_pclk),
        .pix_data         (pix_data),
        .pix_x            (pix_x),
        // Row of the line being captured
        .pix_y            (cam_line_y),
        .pix_valid        (pix_valid),
        .threshold_enable (threshold_enable),
        .threshold_value  (threshold_value),
        .processed_pixel  (processed_pixel),
        .proc_fg          (proc_fg),
        .proc_x           (proc_x),
        .proc_y           (proc_y),
        .proc_valid       (processed_valid)
    );

    centroid_accumulator #(
        .MIN_AREA (MIN_AREA)
    ) i_centroid (
        .pclk            (pclk),
        .r2_rst_pclk     (r2_rst_pclk),
        .proc_fg         (proc_fg),
        .proc_x          (proc_x),
        .proc_y          (proc_y),
        .proc_valid      (processed_valid),
        .frame_end       (frame_end),
        .centroid_x      (centroid_x),
        .centroid_y      (centroid_y),
        .centroid_valid  (centroid_valid),
        .centroid_update (centroid_update),
        .blob_area       (blob_area)
    );

    // ------------------------------------------------------------
    // Pan/tilt direction
    // ------------------------------------------------------------
    motor_direction #(
        .FRAME_WIDTH  (FRAME_WIDTH),
        .FRAME_HEIGHT (FRAME_HEIGHT),
        .DEADBAND     (DEADBAND)
    ) i_motor_dir (
        .pclk            (pclk),
        .r2_rst_pclk     (r2_rst_pclk),
        .motion_enable   (motion_enable),
        .centroid_x      (centroid_x),
        .centroid_y      (centroid_y),
        .centroid_valid  (centroid_valid),
        .centroid_update (centroid_update),
        .direction       (motor_direction)
    );

endmodule

// ==== hw/pixel_proc/centroid_accumulator.sv ====
`timescale 1ns/1ps

module centroid_accumulator #(
    parameter int MIN_AREA = 64
) (
    input  logic               pclk,
    input  logic               r2_rst_pclk,
    input  logic               proc_fg,
    input  vision_pkg::coord_t proc_x,
    input  vision_pkg::coord_t proc_y,
    input  logic               proc_valid,
    input  logic               frame_end,
    output vision_pkg::coord_t centroid_x,
    output vision_pkg::coord_t centroid_y,
    output logic               centroid_valid,
    output logic               centroid_update,
    output vision_pkg::area_t  blob_area
);

    import vision_pkg::*;

    localparam int SUM_W   = $bits(coord_sum_t);
    localparam int REM_W   = $bits(area_t);
    // Divider word is {remainder, dividend/quotient}
    localparam int STATE_W = REM_W + SUM_W;
    localparam int CNT_W   = $clog2(SUM_W);
    localparam int COORD_W = $bits(coord_t);

    // Per-frame accumulators
    area_t      count_acc;
    coord_sum_t sum_x_acc;
    coord_sum_t sum_y_acc;

    // Shared divider control
    logic             busy;
    logic [CNT_W-1:0] bit_cnt;
    logic             start_div;
    logic             short_frame;

    // Divider datapath, one word per axis
    area_t              divisor;
    logic [STATE_W-1:0] div_x;
    logic [STATE_W-1:0] div_y;
    logic [STATE_W-1:0] div_x_next;
    logic [STATE_W-1:0] div_y_next;

    // ------------------------------------------------------------
    // One restoring division step
    // ------------------------------------------------------------
    function automatic logic [STATE_W-1:0] div_step(
        input logic [STATE_W-1:0] cur,
        input area_t              den
    );
        logic [REM_W:0] trial;
        logic [REM_W:0] diff;
        // Remainder shifted left with the next dividend bit
        trial = cur[STATE_W-1 -: REM_W+1];
        diff  = trial - {1'b0, den};
        if (trial >= {1'b0, den}) begin
            return {diff[REM_W-1:0], cur[SUM_W-2:0], 1'b1};
        end
        return {trial[REM_W-1:0], cur[SUM_W-2:0], 1'b0};
    endfunction

    assign div_x_next  = div_step(div_x, divisor);
    assign div_y_next  = div_step(div_y, divisor);
    // Frame end while dividing is dropped
    assign start_div   = frame_end && !busy;
    // Too small a blob skips the division
    assign short_frame = count_acc < area_t'(MIN_AREA);

    // ------------------------------------------------------------
    // Accumulate foreground pixels
    // ------------------------------------------------------------
    always_ff @(posedge pclk or negedge r2_rst_pclk) begin
        if (!r2_rst_pclk) begin
            count_acc <= '0;
            sum_x_acc <= '0;
            sum_y_acc <= '0;
        end else if (start_div) begin
            count_acc <= '0;
            sum_x_acc <= '0;
            sum_y_acc <= '0;
        end else if (proc_valid && proc_fg) begin
            count_acc <= count_acc + 1'b1;
            sum_x_acc <= sum_x_acc + coord_sum_t'(proc_x);
            sum_y_acc <= sum_y_acc + coord_sum_t'(proc_y);
        end
    end

    // ------------------------------------------------------------
    // Divider sequencing and results
    // ------------------------------------------------------------
    always_ff @(posedge pclk or negedge r2_rst_pclk) begin
        if (!r2_rst_pclk) begin
            busy            <= 1'b0;
            bit_cnt         <= '0;
            centroid_update <= 1'b0;
            centroid_valid  <= 1'b0;
            centroid_x      <= '0;
            centroid_y      <= '0;
            blob_area       <= '0;
        end else begin
            centroid_update <= 1'b0;
            if (start_div) begin
                if (short_frame) begin
                    // Report area only, coordinates hold
                    centroid_update <= 1'b1;
                    centroid_valid  <= 1'b0;
                    blob_area       <= count_acc;
                end else begin
                    busy    <= 1'b1;
                    bit_cnt <= CNT_W'(SUM_W - 1);
                end
            end else if (busy) begin
                bit_cnt <= bit_cnt - 1'b1;
                // Last step, quotient complete
                if (bit_cnt == '0) begin
                    busy            <= 1'b0;
                    centroid_update <= 1'b1;
                    centroid_valid  <= 1'b1;
                    blob_area       <= divisor;
                    centroid_x      <= div_x_next[COORD_W-1:0];
                    centroid_y      <= div_y_next[COORD_W-1:0];
                end
            end
        end
    end

    // Load sums at start, then shift-subtract
    always_ff @(posedge pclk) begin
        if (start_div) begin
            divisor <= count_acc;
            div_x   <= {{REM_W{1'b0}}, sum_x_acc};
            div_y   <= {{REM_W{1'b0}}, sum_y_acc};
        end else if (busy) begin
            div_x <= div_x_next;
            div_y <= div_y_next;
        end
    end

endmodule

// ==== hw/pixel_proc/gray_threshold.sv ====
`timescale 1ns/1ps

module gray_threshold (
    input  logic                pclk,
    input  logic                r2_rst_pclk,
    input  vision_pkg::rgb444_t pix_data,
    input  vision_pkg::coord_t  pix_x,
    input  vision_pkg::coord_t  pix_y,
    input  logic                pix_valid,
    input  logic                threshold_enable,
    input  vision_pkg::gray_t   threshold_value,
    output vision_pkg::gray_t   processed_pixel,
    output logic                proc_fg,
    output vision_pkg::coord_t  proc_x,
    output vision_pkg::coord_t  proc_y,
    output logic                proc_valid
);

    import vision_pkg::*;

    // ------------------------------------------------------------
    // Gray level and threshold compare
    // ------------------------------------------------------------

    // R + 2G + B, at most 60
    logic [5:0] weighted_sum;
    gray_t      gray_level;
    logic       is_fg;

    assign weighted_sum = {2'b00, pix_data.r} + {1'b0, pix_data.g, 1'b0} + {2'b00, pix_data.b};
    // Divide by 4, truncated
    assign gray_level   = weighted_sum[5:2];
    assign is_fg        = gray_level >= threshold_value;

    // ------------------------------------------------------------
    // Output stage
    // ------------------------------------------------------------

    // Strobe
    always_ff @(posedge pclk or negedge r2_rst_pclk) begin
        if (!r2_rst_pclk) begin
            proc_valid <= 1'b0;
        end else begin
            proc_valid <= pix_valid;
        end
    end

    // Pixel, flag and coordinates move with the strobe
    always_ff @(posedge pclk) begin
        if (pix_valid) begin
            // Binary image when thresholding, gray otherwise
            if (threshold_enable) begin
                processed_pixel <= is_fg ? 4'hf : 4'h0;
            end else begin
                processed_pixel <= gray_level;
            end
            proc_fg <= is_fg;
            proc_x  <= pix_x;
            proc_y  <= pix_y;
        end
    end

endmodule

// ==== verification/tb_object_tracker_tasks.svh ====
`ifndef TB_OBJECT_TRACKER_TASKS_SVH
`define TB_OBJECT_TRACKER_TASKS_SVH

// ------------------------------------------------------------
// Compare and reference model
// ------------------------------------------------------------
task automatic compare_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    check_cnt++;
    if (actual !== expected) begin
        mismatch_cnt++;
        $display("Mismatch at time %0t: %s expected %0d, actual %0d",
                 $time, name, expected, actual);
    end
endtask

// Gray level of a byte pair is (R + 2G + B) / 4
function automatic int gray_of(input logic [7:0] first, input logic [7:0] second);
    int red;
    int green;
    int blue;
    red   = first[3:0];
    green = second[7:4];
    blue  = second[3:0];
    return (red + 2 * green + blue) / 4;
endfunction

// ------------------------------------------------------------
// Camera drivers
// ------------------------------------------------------------

// Vsync pulse before a new frame
task automatic pulse_vsync();
    @(negedge pclk);
    vsync = 1'b1;
    repeat (3) @(negedge pclk);
    vsync = 1'b0;
    repeat (6) @(negedge pclk);
endtask

// One line from line_bytes followed by 6 idle cycles
task automatic send_line();
    int i;
    for (i = 0; i < LINE_BYTES; i++) begin
        @(negedge pclk);
        href     = 1'b1;
        pix_byte = line_bytes[i];
    end
    @(negedge pclk);
    href     = 1'b0;
    pix_byte = 8'h00;
    repeat (5) @(negedge pclk);
endtask

// White pixels inside the rectangle and black elsewhere
task automatic fill_rect_row(input int row, input int x0, input int x1,
                             input int y0, input int y1);
    int col;
    for (col = 0; col < FRAME_W; col++) begin
        if (row >= y0 && row <= y1 && col >= x0 && col <= x1) begin
            line_bytes[2 * col]     = 8'h0f;
            line_bytes[2 * col + 1] = 8'hff;
        end else begin
            line_bytes[2 * col]     = 8'h00;
            line_bytes[2 * col + 1] = 8'h00;
        end
    end
endtask

task automatic send_rect_frame(input int x0, input int x1, input int y0, input int y1);
    int row;
    pulse_vsync();
    for (row = 0; row < FRAME_H; row++) begin
        fill_rect_row(row, x0, x1, y0, y1);
        send_line();
    end
endtask

// ------------------------------------------------------------
// Bounded waits
// ------------------------------------------------------------

// Raise vsync to close the frame and hold it until the centroid result
task automatic close_frame_wait();
    int   n;
    logic seen;
    seen = 1'b0;
    @(negedge pclk);
    vsync = 1'b1;
    for (n = 0; n < 100 && !seen; n++) begin
        @(negedge pclk);
        if (centroid_update) begin
            seen      = 1'b1;
            got_area  = blob_area;
            got_x     = centroid_x;
            got_y     = centroid_y;
            got_valid = centroid_valid;
        end
    end
    if (!seen) begin
        timeout_cnt++;
        $display("Timeout at time %0t: centroid_update never came after the frame ended",
                 $time);
    end
    vsync = 1'b0;
    repeat (6) @(negedge pclk);
endtask

task automatic wait_line_ready(input int target);
    int n;
    for (n = 0; n < 50 && line_ready_cnt < target; n++) begin
        @(negedge pclk);
    end
    if (line_ready_cnt < target) begin
        timeout_cnt++;
        $display("Timeout at time %0t: cam_line_ready never pulsed for line %0d",
                 $time, target);
    end
endtask

// ------------------------------------------------------------
// Result checks
// ------------------------------------------------------------

// Pixel stream of one line against expected_px
task automatic collect_and_check_line();
    int i;
    collected.delete();
    collect_on = 1'b1;
    send_line();
    collect_on = 1'b0;
    compare_value("processed_valid count", FRAME_W, collected.size());
    for (i = 0; i < expected_px.size() && i < collected.size(); i++) begin
        compare_value($sformatf("processed_pixel[%0d]", i), expected_px[i], collected[i]);
    end
endtask

// Area and means of a filled rectangle
task automatic check_rect_result(input int x0, input int x1, input int y0, input int y1);
    int area;
    int sum_x;
    int sum_y;
    int row;
    int col;
    area  = 0;
    sum_x = 0;
    sum_y = 0;
    for (row = y0; row <= y1; row++) begin
        for (col = x0; col <= x1; col++) begin
            area++;
            sum_x += col;
            sum_y += row;
        end
    end
    compare_value("blob_area", area, got_area);
    if (area >= MIN_PIX) begin
        exp_x = sum_x / area;
        exp_y = sum_y / area;
        compare_value("centroid_valid", 1, got_valid);
    end else begin
        // Too small a blob keeps the last valid centroid
        compare_value("centroid_valid", 0, got_valid);
    end
    compare_value("centroid_x", exp_x, got_x);
    compare_value("centroid_y", exp_y, got_y);
endtask

// ------------------------------------------------------------
// Directed tests
// ------------------------------------------------------------
task automatic test_reset_state();
    @(negedge pclk);
    compare_value("processed_valid", 0, processed_valid);
    compare_value("cam_line_ready", 0, cam_line_ready);
    compare_value("centroid_update", 0, centroid_update);
    compare_value("centroid_valid", 0, centroid_valid);
    compare_value("motor_direction", 0, motor_direction);
    compare_value("cam_line_y", 0, cam_line_y);
    compare_value("centroid_x", 0, centroid_x);
    compare_value("centroid_y", 0, centroid_y);
    compare_value("blob_area", 0, blob_area);
endtask

task automatic test_gray_path();
    int     i;
    integer rnd;
    threshold_enable = 1'b0;
    for (i = 0; i < LINE_BYTES; i++) begin
        rnd           = $random(seed);
        line_bytes[i] = rnd[7:0];
    end
    expected_px.delete();
    for (i = 0; i < FRAME_W; i++) begin
        expected_px.push_back(gray_of(line_bytes[2 * i], line_bytes[2 * i + 1]));
    end
    collect_and_check_line();
endtask

task automatic test_threshold_path();
    int     i;
    integer rnd;
    threshold_enable = 1'b1;
    threshold_value  = 4'd8;
    for (i = 0; i < LINE_BYTES; i++) begin
        rnd           = $random(seed);
        line_bytes[i] = rnd[7:0];
    end
    expected_px.delete();
    for (i = 0; i < FRAME_W; i++) begin
        expected_px.push_back(gray_of(line_bytes[2 * i], line_bytes[2 * i + 1]) >= 8 ? 15 : 0);
    end
    collect_and_check_line();
endtask

// One line more than the frame height to see the wrap
task automatic test_line_counting();
    int i;
    int base;
    for (i = 0; i < LINE_BYTES; i++) begin
        line_bytes[i] = 8'h00;
    end
    pulse_vsync();
    compare_value("cam_line_y", 0, cam_line_y);
    base = line_ready_cnt;
    for (i = 0; i < FRAME_H + 1; i++) begin
        send_line();
        wait_line_ready(base + i + 1);
        compare_value("cam_line_ready count", i + 1, line_ready_cnt - base);
        compare_value("cam_line_y", (i + 1) % FRAME_H, cam_line_y);
    end
endtask

task automatic test_centroid();
    threshold_enable = 1'b1;
    threshold_value  = 4'd8;
    send_rect_frame(4, 9, 2, 4);
    close_frame_wait();
    check_rect_result(4, 9, 2, 4);
    // Two pixels are below the minimum area
    send_rect_frame(5, 6, 3, 3);
    close_frame_wait();
    check_rect_result(5, 6, 3, 3);
endtask

task automatic test_motor_direction();
    logic [3:0] left_up;
    left_up           = 4'b0000;
    left_up[DIR_LEFT] = 1'b1;
    left_up[DIR_UP]   = 1'b1;
    motion_enable = 1'b1;
    // Top left corner lies left of and above the centre window
    send_rect_frame(0, 3, 0, 1);
    close_frame_wait();
    check_rect_result(0, 3, 0, 1);
    compare_value("motor_direction", left_up, motor_direction);
    // Inside the deadband
    send_rect_frame(6, 9, 3, 4);
    close_frame_wait();
    check_rect_result(6, 9, 3, 4);
    compare_value("motor_direction", 0, motor_direction);
    send_rect_frame(0, 3, 0, 1);
    close_frame_wait();
    compare_value("motor_direction", left_up, motor_direction);
    // Motion off clears the code
    motion_enable = 1'b0;
    repeat (2) @(negedge pclk);
    compare_value("motor_direction", 0, motor_direction);
endtask

`endif

// ==== verification/tb_object_tracker.sv ====
`timescale 1ns/1ps

module tb_object_tracker;

    import vision_pkg::*;

    // Small frame so whole frames run quickly
    localparam int FRAME_W    = 16;
    localparam int FRAME_H    = 8;
    localparam int MIN_PIX    = 4;
    localparam int DEAD       = 2;
    localparam int LINE_BYTES = 2 * FRAME_W;

    // DUT inputs
    logic       pclk;
    logic       r2_rst_pclk;
    logic [7:0] pix_byte;
    logic       vsync;
    logic       href;
    logic       threshold_enable;
    gray_t      threshold_value;
    logic       motion_enable;

    // DUT outputs
    gray_t      processed_pixel;
    logic       processed_valid;
    coord_t     cam_line_y;
    logic       cam_line_ready;
    coord_t     centroid_x;
    coord_t     centroid_y;
    logic       centroid_valid;
    logic       centroid_update;
    area_t      blob_area;
    motor_dir_t motor_direction;

    // Result counters
    int         check_cnt;
    int         mismatch_cnt;
    int         timeout_cnt;
    integer     seed;

    // Monitor state
    int         line_ready_cnt;
    logic       collect_on;
    int         collected[$];
    int         expected_px[$];

    // Byte image of the next camera line
    logic [7:0] line_bytes[LINE_BYTES];

    // Centroid values seen with the last update, and the model's last valid means
    area_t      got_area;
    coord_t     got_x;
    coord_t     got_y;
    logic       got_valid;
    int         exp_x;
    int         exp_y;

    object_tracker_top #(
        .FRAME_WIDTH  (FRAME_W),
        .FRAME_HEIGHT (FRAME_H),
        .MIN_AREA     (MIN_PIX),
        .DEADBAND     (DEAD)
    ) i_dut (
        .pclk             (pclk),
        .r2_rst_pclk      (r2_rst_pclk),
        .pix_byte         (pix_byte),
        .vsync            (vsync),
        .href             (href),
        .threshold_enable (threshold_enable),
        .threshold_value  (threshold_value),
        .motion_enable    (motion_enable),
        .processed_pixel  (processed_pixel),
        .processed_valid  (processed_valid),
        .cam_line_y       (cam_line_y),
        .cam_line_ready   (cam_line_ready),
        .centroid_x       (centroid_x),
        .centroid_y       (centroid_y),
        .centroid_valid   (centroid_valid),
        .centroid_update  (centroid_update),
        .blob_area        (blob_area),
        .motor_direction  (motor_direction)
    );

    // 8 ns clock period
    always #4 pclk = ~pclk;

    // ------------------------------------------------------------
    // Monitors, sampling the values from before each rising edge
    // ------------------------------------------------------------
    always @(posedge pclk) begin
        if (cam_line_ready) begin
            line_ready_cnt++;
        end
        // Processed pixel stream, only while a test listens
        if (collect_on && processed_valid) begin
            collected.push_back(int'(processed_pixel));
        end
    end

    `include "tb_object_tracker_tasks.svh"

    // ------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------
    initial begin
        pclk             = 1'b0;
        r2_rst_pclk      = 1'b0;
        pix_byte         = 8'h00;
        vsync            = 1'b0;
        href             = 1'b0;
        threshold_enable = 1'b0;
        threshold_value  = 4'd8;
        motion_enable    = 1'b0;
        check_cnt        = 0;
        mismatch_cnt     = 0;
        timeout_cnt      = 0;
        line_ready_cnt   = 0;
        collect_on       = 1'b0;
        exp_x            = 0;
        exp_y            = 0;
        seed             = 61634;

        // Reset for 4 clock cycles, released on a falling edge
        repeat (4) @(negedge pclk);
        r2_rst_pclk = 1'b1;

        test_reset_state();
        test_gray_path();
        test_threshold_path();
        test_line_counting();
        test_centroid();
        test_motor_direction();

        $display("Checks: %0d, mismatches: %0d, timeouts: %0d",
                 check_cnt, mismatch_cnt, timeout_cnt);
        if (mismatch_cnt == 0 && timeout_cnt == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule
